// File: rtl/isf_pkg.sv
// ISF support package with stream widths, TLV type codes, debug modes and watermark constants
`default_nettype none

package isf_pkg;

  // FIFO occupancy, wide enough for 0 to 128
  typedef logic [7:0] fifo_depth_t;

  // Watermark select code
  typedef logic [2:0] wmark_sel_t;

  // Stream beat and sideband
  typedef logic [63:0] tdata_t;
  typedef logic [1:0]  tuser_t;

  // TLV type field of word 0
  typedef logic [7:0] tlv_type_t;

  // Stall counter and limit
  typedef logic [31:0] stall_cnt_t;

  localparam fifo_depth_t ISF_FIFO_ENTRIES = 8'd128;

  // Watermark = (sel + 1) * step
  localparam fifo_depth_t WMARK_STEP = 8'd8;

  // Sideband bit positions
  localparam int TUSER_SOT = 0;
  localparam int TUSER_EOT = 1;

  localparam int TLV_TYPE_LSB = 0;

  localparam tlv_type_t TLV_RQE = 8'h01;
  localparam tlv_type_t TLV_CMD = 8'h02;
  localparam tlv_type_t TLV_CQE = 8'h03;

  // Code 3 is unnamed and acts as normal without forced back-pressure
  typedef enum logic [1:0] {
    DBG_NORMAL   = 2'd0,
    DBG_BLK_RDWR = 2'd1,
    DBG_BLK_RD   = 2'd2
  } debug_mode_e;

endpackage : isf_pkg

`default_nettype wire

// File: rtl/isf_fifo_flow.sv
// ISF flow control with watermark decode, hysteresis full FSM, debug gating and parser-FIFO write
`default_nettype none

module isf_fifo_flow
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  isf_pkg::wmark_sel_t   use_wmark_sel,
  input  isf_pkg::wmark_sel_t   req_wmark_sel,
  input  isf_pkg::debug_mode_e  debug_mode,
  input  wire                   force_ib_bp,
  input  wire                   axi_slv_empty,
  input  isf_pkg::fifo_depth_t  isf_fifo_depth,
  input  wire                   pre_tlvp_fifo_afull,
  output logic                  axi_slv_rd,
  output logic                  isf_fifo_hw_rd,
  output logic                  pre_tlvp_fifo_wr
);

  import isf_pkg::*;

  typedef enum logic {FULL_IDLE, FULL_BP} full_st_e;

  full_st_e     full_st;
  fifo_depth_t  use_wmark;
  fifo_depth_t  req_wmark;
  fifo_depth_t  use_wmark_depth;
  fifo_depth_t  req_wmark_depth;
  logic         use_wmark_hit;
  logic         req_wmark_hit;
  logic         fifo_full;
  logic         fifo_nonempty;
  logic         hw_rd_pre;
  logic         hw_wr_pre;

  assign use_wmark = (fifo_depth_t'(use_wmark_sel) + 8'd1) * WMARK_STEP;
  assign req_wmark = (fifo_depth_t'(req_wmark_sel) + 8'd1) * WMARK_STEP;

  // Sum is at most 128, so the low threshold never wraps
  assign use_wmark_depth = ISF_FIFO_ENTRIES - use_wmark;
  assign req_wmark_depth = ISF_FIFO_ENTRIES - (use_wmark + req_wmark);

  assign use_wmark_hit = isf_fifo_depth >= use_wmark_depth;
  assign req_wmark_hit = isf_fifo_depth <= req_wmark_depth;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full_st <= FULL_IDLE;
    end
    else
    begin
      case (full_st)
        FULL_IDLE: if (use_wmark_hit) full_st <= FULL_BP;
        FULL_BP:   if (req_wmark_hit) full_st <= FULL_IDLE;
        default:   full_st <= FULL_IDLE;
      endcase
    end
  end

  assign fifo_full     = (full_st == FULL_BP);
  assign fifo_nonempty = (isf_fifo_depth != '0);

  assign hw_wr_pre = !axi_slv_empty && !fifo_full;
  assign hw_rd_pre = fifo_nonempty && !pre_tlvp_fifo_afull;

  always_comb
  begin
    case (debug_mode)
      DBG_NORMAL:
      begin
        axi_slv_rd     = hw_wr_pre && !force_ib_bp;
        isf_fifo_hw_rd = hw_rd_pre;
      end
      DBG_BLK_RDWR:
      begin
        axi_slv_rd     = 1'b0;
        isf_fifo_hw_rd = 1'b0;
      end
      DBG_BLK_RD:
      begin
        axi_slv_rd     = hw_wr_pre;
        isf_fifo_hw_rd = 1'b0;
      end
      default:
      begin
        axi_slv_rd     = hw_wr_pre;       // Code 3 ignores force_ib_bp
        isf_fifo_hw_rd = hw_rd_pre;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pre_tlvp_fifo_wr <= 1'b0;
    else
      pre_tlvp_fifo_wr <= isf_fifo_hw_rd && !pre_tlvp_fifo_afull;
  end

endmodule : isf_fifo_flow

`default_nettype wire

// File: rtl/isf_ib_parser.sv
// ISF inbound TLV parser with RQE and CQE receive pulses and CMD debug mask
`default_nettype none

module isf_ib_parser
(
  input  wire              clk,
  input  wire              rst_n,
  input  isf_pkg::tdata_t  axi_slv_tdata,
  input  isf_pkg::tuser_t  axi_slv_tuser,
  input  wire              axi_slv_tvalid,
  input  wire              axi_slv_rd,
  output logic             isf_sup_rqe_rx,
  output logic             isf_sup_cqe_rx,
  output logic             mask_debug
);

  import isf_pkg::*;

  typedef enum logic [1:0] {
    IB_IDLE,
    IB_RQE_FOUND,
    IB_CMD_FOUND,
    IB_CQE_FOUND
  } ib_st_e;

  ib_st_e     ib_st;
  tlv_type_t  tlv_type;
  logic       beat_acc;
  logic       sot_beat;
  logic       eot_beat;

  assign tlv_type = axi_slv_tdata[TLV_TYPE_LSB +: $bits(tlv_type_t)];
  assign beat_acc = axi_slv_rd && axi_slv_tvalid;
  assign sot_beat = beat_acc && axi_slv_tuser[TUSER_SOT];
  assign eot_beat = beat_acc && axi_slv_tuser[TUSER_EOT];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ib_st          <= IB_IDLE;
      isf_sup_rqe_rx <= 1'b0;
      isf_sup_cqe_rx <= 1'b0;
    end
    else
    begin
      isf_sup_rqe_rx <= 1'b0;
      isf_sup_cqe_rx <= 1'b0;

      case (ib_st)
        IB_IDLE:
        begin
          if (sot_beat && (tlv_type == TLV_RQE))
          begin
            isf_sup_rqe_rx <= 1'b1;
            ib_st          <= IB_RQE_FOUND;
          end
        end

        IB_RQE_FOUND:
        begin
          if (sot_beat && (tlv_type == TLV_CQE))
          begin
            isf_sup_cqe_rx <= 1'b1;
            ib_st          <= IB_CQE_FOUND;
          end
          else if (sot_beat && (tlv_type == TLV_CMD))
          begin
            ib_st <= IB_CMD_FOUND;
          end
        end

        // One accepted beat past the CMD header
        IB_CMD_FOUND:
        begin
          if (beat_acc)
            ib_st <= IB_RQE_FOUND;
        end

        IB_CQE_FOUND:
        begin
          if (eot_beat)
            ib_st <= IB_IDLE;
        end

        default: ib_st <= IB_IDLE;
      endcase
    end
  end

  assign mask_debug = (ib_st == IB_CMD_FOUND);   // Decoded from state register

endmodule : isf_ib_parser

`default_nettype wire

// File: rtl/isf_ob_parser.sv
// ISF outbound parser detecting the end of a CQE leaving the block
`default_nettype none

module isf_ob_parser
(
  input  wire              clk,
  input  wire              rst_n,
  input  isf_pkg::tdata_t  isf_ob_tdata,
  input  isf_pkg::tuser_t  isf_ob_tuser,
  input  wire              isf_ob_tvalid,
  input  wire              isf_ob_tready,
  output logic             isf_sup_cqe_exit
);

  import isf_pkg::*;

  typedef enum logic {OB_IDLE, OB_CQE_FOUND} ob_st_e;

  ob_st_e     ob_st;
  tlv_type_t  tlv_type;
  logic       xfer;

  assign tlv_type = isf_ob_tdata[TLV_TYPE_LSB +: $bits(tlv_type_t)];
  assign xfer     = isf_ob_tvalid && isf_ob_tready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ob_st            <= OB_IDLE;
      isf_sup_cqe_exit <= 1'b0;
    end
    else
    begin
      isf_sup_cqe_exit <= 1'b0;
      case (ob_st)
        OB_IDLE:
          if (xfer && isf_ob_tuser[TUSER_SOT] && (tlv_type == TLV_CQE))
            ob_st <= OB_CQE_FOUND;
        OB_CQE_FOUND:
          if (xfer && isf_ob_tuser[TUSER_EOT])
          begin
            isf_sup_cqe_exit <= 1'b1;
            ob_st            <= OB_IDLE;
          end
        default: ob_st <= OB_IDLE;
      endcase
    end
  end

endmodule : isf_ob_parser

`default_nettype wire

// File: rtl/isf_intr_gen.sv
// ISF interrupt generation with system-stall timer and overflow edge detect
`default_nettype none

module isf_intr_gen
(
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  sys_stall_en,
  input  isf_pkg::stall_cnt_t  sys_stall_limit,
  input  wire                  isf_ob_tvalid,
  input  wire                  isf_ob_tready,
  input  wire                  axi_slv_ovfl,
  output logic                 isf_sys_stall_intr,
  output logic                 ovfl_int
);

  import isf_pkg::*;

  typedef enum logic {STALL_IDLE, STALL_CNT} stall_st_e;

  stall_st_e   stall_st;
  stall_cnt_t  stall_cnt;
  logic        stall_cyc;
  logic        limit_hit;
  logic        axi_slv_ovfl_d;

  // Outbound data waiting with no ready
  assign stall_cyc = isf_ob_tvalid && !isf_ob_tready && sys_stall_en;
  assign limit_hit = (stall_cnt == sys_stall_limit);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stall_st           <= STALL_IDLE;
      stall_cnt          <= '0;
      isf_sys_stall_intr <= 1'b0;
    end
    else
    begin
      isf_sys_stall_intr <= 1'b0;
      case (stall_st)
        STALL_IDLE:
        begin
          if (stall_cyc)
          begin
            stall_cnt <= stall_cnt_t'(1);
            stall_st  <= STALL_CNT;
          end
          else
          begin
            stall_cnt <= '0;
          end
        end

        STALL_CNT:
        begin
          if (limit_hit)
          begin
            isf_sys_stall_intr <= 1'b1;
            stall_cnt          <= '0;
            stall_st           <= STALL_IDLE;
          end
          else if (stall_cyc)
          begin
            stall_cnt <= stall_cnt + stall_cnt_t'(1);
          end
          else
          begin
            stall_cnt <= '0;              // Stall broken, start over
            stall_st  <= STALL_IDLE;
          end
        end

        default: stall_st <= STALL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      axi_slv_ovfl_d <= 1'b0;
      ovfl_int       <= 1'b0;
    end
    else
    begin
      axi_slv_ovfl_d <= axi_slv_ovfl;
      ovfl_int       <= axi_slv_ovfl && !axi_slv_ovfl_d;   // Rising edge only
    end
  end

endmodule : isf_intr_gen

`default_nettype wire

// File: rtl/isf_support.sv
// ISF support top level connecting flow control, parsers and interrupt generation
`default_nettype none

module isf_support
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  isf_pkg::wmark_sel_t   use_wmark_sel,
  input  isf_pkg::wmark_sel_t   req_wmark_sel,
  input  isf_pkg::debug_mode_e  debug_mode,
  input  wire                   force_ib_bp,
  input  wire                   sys_stall_en,
  input  isf_pkg::stall_cnt_t   sys_stall_limit,
  input  isf_pkg::tdata_t       axi_slv_tdata,
  input  isf_pkg::tuser_t       axi_slv_tuser,
  input  wire                   axi_slv_tvalid,
  input  wire                   axi_slv_empty,
  input  wire                   axi_slv_ovfl,
  input  isf_pkg::fifo_depth_t  isf_fifo_depth,
  input  wire                   pre_tlvp_fifo_afull,
  input  isf_pkg::tdata_t       isf_ob_tdata,
  input  isf_pkg::tuser_t       isf_ob_tuser,
  input  wire                   isf_ob_tvalid,
  input  wire                   isf_ob_tready,
  output logic                  axi_slv_rd,
  output logic                  isf_fifo_hw_rd,
  output logic                  pre_tlvp_fifo_wr,
  output logic                  isf_sup_rqe_rx,
  output logic                  isf_sup_cqe_rx,
  output logic                  isf_sup_cqe_exit,
  output logic                  mask_debug,
  output logic                  isf_sys_stall_intr,
  output logic                  ovfl_int
);

  isf_fifo_flow i_isf_fifo_flow (
    .clk                 (clk),
    .rst_n               (rst_n),
    .use_wmark_sel       (use_wmark_sel),
    .req_wmark_sel       (req_wmark_sel),
    .debug_mode          (debug_mode),
    .force_ib_bp         (force_ib_bp),
    .axi_slv_empty       (axi_slv_empty),
    .isf_fifo_depth      (isf_fifo_depth),
    .pre_tlvp_fifo_afull (pre_tlvp_fifo_afull),
    .axi_slv_rd          (axi_slv_rd),
    .isf_fifo_hw_rd      (isf_fifo_hw_rd),
    .pre_tlvp_fifo_wr    (pre_tlvp_fifo_wr)
  );

  // Inbound beats count only when the flow block accepts them
  isf_ib_parser i_isf_ib_parser (
    .clk            (clk),
    .rst_n          (rst_n),
    .axi_slv_tdata  (axi_slv_tdata),
    .axi_slv_tuser  (axi_slv_tuser),
    .axi_slv_tvalid (axi_slv_tvalid),
    .axi_slv_rd     (axi_slv_rd),
    .isf_sup_rqe_rx (isf_sup_rqe_rx),
    .isf_sup_cqe_rx (isf_sup_cqe_rx),
    .mask_debug     (mask_debug)
  );

  isf_ob_parser i_isf_ob_parser (
    .clk              (clk),
    .rst_n            (rst_n),
    .isf_ob_tdata     (isf_ob_tdata),
    .isf_ob_tuser     (isf_ob_tuser),
    .isf_ob_tvalid    (isf_ob_tvalid),
    .isf_ob_tready    (isf_ob_tready),
    .isf_sup_cqe_exit (isf_sup_cqe_exit)
  );

  isf_intr_gen i_isf_intr_gen (
    .clk                (clk),
    .rst_n              (rst_n),
    .sys_stall_en       (sys_stall_en),
    .sys_stall_limit    (sys_stall_limit),
    .isf_ob_tvalid      (isf_ob_tvalid),
    .isf_ob_tready      (isf_ob_tready),
    .axi_slv_ovfl       (axi_slv_ovfl),
    .isf_sys_stall_intr (isf_sys_stall_intr),
    .ovfl_int           (ovfl_int)
  );

endmodule : isf_support

`default_nettype wire

// File: tests/isf_tb_table.svh
// Stimulus and expected-value rows for the table-driven ISF support tests
// Columns: test, mode, force_ib_bp, empty, depth, afull, tvalid, tuser, tlv type, ovfl, expected
// Expected bits: axi_slv_rd, isf_fifo_hw_rd, pre_tlvp_fifo_wr, rqe_rx, cqe_rx, mask_debug, ovfl_int
// Registered bits show the result of the row above

task automatic load_table();
  // Watermarks 16 and 8, set at 112 and clear at 104
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd100, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1100000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd112, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd112, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0110000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd105, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0110000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd105, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0110000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd104, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0110000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd104, 1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110000});
  tbl.push_back({2'd0, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110000});
  // Debug modes, forced back-pressure and afull
  tbl.push_back({2'd1, 2'd1, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0010000});
  tbl.push_back({2'd1, 2'd1, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0000000});
  tbl.push_back({2'd1, 2'd2, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1000000});
  tbl.push_back({2'd1, 2'd0, 1'b1, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0100000});
  tbl.push_back({2'd1, 2'd2, 1'b1, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1010000});
  tbl.push_back({2'd1, 2'd1, 1'b1, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0000000});
  tbl.push_back({2'd1, 2'd0, 1'b0, 1'b0, 8'd50,  1'b1, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1000000});
  tbl.push_back({2'd1, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1100000});
  tbl.push_back({2'd1, 2'd0, 1'b0, 1'b0, 8'd50,  1'b1, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1010000});
  tbl.push_back({2'd1, 2'd0, 1'b0, 1'b1, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b0100000});
  tbl.push_back({2'd1, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110000});
  // RQE, CMD, data, CQE, EOT, then CQE while idle and while blocked
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b01, TLV_RQE, 1'b0, 7'b1110000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b01, TLV_CMD, 1'b0, 7'b1111000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b00, 8'h00,   1'b0, 7'b1110010});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b01, TLV_CQE, 1'b0, 7'b1110000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b10, 8'h00,   1'b0, 7'b1110100});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b0, 2'b00, 8'h00,   1'b0, 7'b1110000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b01, TLV_CQE, 1'b0, 7'b1110000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b0, 2'b00, 8'h00,   1'b0, 7'b1110000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b1, 2'b01, TLV_RQE, 1'b0, 7'b1110000});
  tbl.push_back({2'd2, 2'd0, 1'b1, 1'b0, 8'd50, 1'b0, 1'b1, 2'b01, TLV_CQE, 1'b0, 7'b0111000});
  tbl.push_back({2'd2, 2'd0, 1'b0, 1'b0, 8'd50, 1'b0, 1'b0, 2'b00, 8'h00,   1'b0, 7'b1110000});
  // Overflow level with two rising edges
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b1, 7'b1110000});
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b1, 7'b1110001});
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b1, 7'b1110000});
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110000});
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b1, 7'b1110000});
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110001});
  tbl.push_back({2'd3, 2'd0, 1'b0, 1'b0, 8'd50,  1'b0, 1'b0, 2'b00, 8'h00, 1'b0, 7'b1110000});
endtask

// File: tests/isf_support_tb.sv
// Testbench for the ISF support block with table tests, outbound exit and stall interrupt tests
`default_nettype none

module isf_support_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import isf_pkg::*;

  typedef struct packed {
    logic [1:0] tst;
    logic [1:0] mode;
    logic       bp;
    logic       empty;
    logic [7:0] depth;
    logic       afull;
    logic       tvalid;
    logic [1:0] tuser;
    logic [7:0] ttype;
    logic       ovfl;
    logic [6:0] exp;
  } row_t;

  logic clk;
  logic rst_n;
  wmark_sel_t use_wmark_sel;
  wmark_sel_t req_wmark_sel;
  debug_mode_e debug_mode;
  logic force_ib_bp;
  logic sys_stall_en;
  stall_cnt_t sys_stall_limit;
  tdata_t axi_slv_tdata;
  tuser_t axi_slv_tuser;
  logic axi_slv_tvalid;
  logic axi_slv_empty;
  logic axi_slv_ovfl;
  fifo_depth_t isf_fifo_depth;
  logic pre_tlvp_fifo_afull;
  tdata_t isf_ob_tdata;
  tuser_t isf_ob_tuser;
  logic isf_ob_tvalid;
  logic isf_ob_tready;
  logic axi_slv_rd;
  logic isf_fifo_hw_rd;
  logic pre_tlvp_fifo_wr;
  logic isf_sup_rqe_rx;
  logic isf_sup_cqe_rx;
  logic isf_sup_cqe_exit;
  logic mask_debug;
  logic isf_sys_stall_intr;
  logic ovfl_int;

  int seed;
  int err_cnt;
  int err_base;
  int tests_run;
  int tests_failed;
  int edges;
  logic found;
  row_t tbl [$];
  string out_name [7] = '{"axi_slv_rd", "isf_fifo_hw_rd", "pre_tlvp_fifo_wr",
                          "isf_sup_rqe_rx", "isf_sup_cqe_rx", "mask_debug", "ovfl_int"};
  string tbl_name [4] = '{"watermark hysteresis", "debug gating", "inbound sequence",
                          "overflow"};

  `include "isf_tb_table.svh"

  isf_support i_isf_support (.*);

  always #5 clk = ~clk;

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == err_base)
      $display("test %s passed", name);
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d mismatches", name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  // One row per cycle, outputs sampled mid-cycle
  task automatic apply_row(input row_t r);
    logic [63:0] rnd;
    logic [6:0]  act;
    int          b;
    @(posedge clk);
    #1;
    rnd                 = {$random(seed), $random(seed)};
    debug_mode          = debug_mode_e'(r.mode);
    force_ib_bp         = r.bp;
    axi_slv_empty       = r.empty;
    isf_fifo_depth      = r.depth;
    pre_tlvp_fifo_afull = r.afull;
    axi_slv_tvalid      = r.tvalid;
    axi_slv_tuser       = r.tuser;
    axi_slv_tdata       = {rnd[63:8], r.ttype};
    axi_slv_ovfl        = r.ovfl;
    #5;
    act = {axi_slv_rd, isf_fifo_hw_rd, pre_tlvp_fifo_wr, isf_sup_rqe_rx, isf_sup_cqe_rx,
           mask_debug, ovfl_int};
    for (b = 0; b < 7; b++)
      check(out_name[b], 32'(act[6-b]), 32'(r.exp[6-b]));
  endtask

  task automatic ob_beat(input logic v, input logic r, input tuser_t u, input tlv_type_t t,
                         input logic exp_exit);
    @(posedge clk);
    #1;
    isf_ob_tvalid = v;
    isf_ob_tready = r;
    isf_ob_tuser  = u;
    isf_ob_tdata  = {56'($random(seed)), t};
    #5;
    check("isf_sup_cqe_exit", 32'(isf_sup_cqe_exit), 32'(exp_exit));
  endtask

  // Counts edges until the stall interrupt, gives up after 50
  task automatic count_to_intr(output int n, output logic hit);
    n   = 0;
    hit = 1'b0;
    while (n < 50 && !hit)
    begin
      @(posedge clk);
      #1;
      n++;
      hit = isf_sys_stall_intr;
    end
  endtask

  task automatic expect_stall_intr();
    count_to_intr(edges, found);
    if (!found)
    begin
      $display("Timeout: no system stall interrupt within 50 cycles at t=%0t", $time);
      err_cnt++;
    end
    else
      check("isf_sys_stall_intr edge count", edges, sys_stall_limit + 32'd1);
  endtask

  initial
  begin
    seed = 32'h86338be3;
    clk = 1'b0;
    rst_n = 1'b0;
    use_wmark_sel = 3'd1;
    req_wmark_sel = 3'd0;
    debug_mode = DBG_NORMAL;
    force_ib_bp = 1'b0;
    sys_stall_en = 1'b0;
    sys_stall_limit = 32'd5;
    axi_slv_tdata = '0;
    axi_slv_tuser = '0;
    axi_slv_tvalid = 1'b0;
    axi_slv_empty = 1'b1;
    axi_slv_ovfl = 1'b0;
    isf_fifo_depth = '0;
    pre_tlvp_fifo_afull = 1'b0;
    isf_ob_tdata = '0;
    isf_ob_tuser = '0;
    isf_ob_tvalid = 1'b0;
    isf_ob_tready = 1'b0;
    err_cnt = 0;
    err_base = 0;
    tests_run = 0;
    tests_failed = 0;

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    load_table();
    for (int i = 0; i < tbl.size(); i++)
    begin
      apply_row(tbl[i]);
      if (i == tbl.size() - 1 || tbl[i+1].tst != tbl[i].tst)
        end_test(tbl_name[tbl[i].tst]);
    end

    // SOT CQE, stalled EOT, then the EOT transfer
    ob_beat(1'b1, 1'b1, 2'b01, TLV_CQE, 1'b0);
    ob_beat(1'b1, 1'b0, 2'b10, 8'h00, 1'b0);
    ob_beat(1'b1, 1'b1, 2'b10, 8'h00, 1'b0);
    ob_beat(1'b0, 1'b0, 2'b00, 8'h00, 1'b1);
    ob_beat(1'b0, 1'b0, 2'b00, 8'h00, 1'b0);
    end_test("outbound cqe exit");

    @(posedge clk);
    #1;
    sys_stall_en  = 1'b1;
    isf_ob_tvalid = 1'b1;
    isf_ob_tready = 1'b0;
    expect_stall_intr();
    @(posedge clk);
    #1;
    check("isf_sys_stall_intr", 32'(isf_sys_stall_intr), 32'd0);   // Single-cycle pulse
    isf_ob_tready = 1'b1;
    @(posedge clk);
    #1;
    isf_ob_tready = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    isf_ob_tready = 1'b1;                  // Break the stall
    @(posedge clk);
    #1;
    isf_ob_tready = 1'b0;
    expect_stall_intr();
    @(posedge clk);
    #1;
    sys_stall_en = 1'b0;
    count_to_intr(edges, found);
    check("isf_sys_stall_intr", 32'(found), 32'd0);
    end_test("stall interrupt");

    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule : isf_support_tb

`default_nettype wire

// File: compile.f
+incdir+tests
rtl/isf_pkg.sv
rtl/isf_fifo_flow.sv
rtl/isf_ib_parser.sv
rtl/isf_ob_parser.sv
rtl/isf_intr_gen.sv
rtl/isf_support.sv
tests/isf_support_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ISF support testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --timescale 1ns/1ps -f compile.f \
  --top-module isf_support_tb -o isf_sim > build.log 2>&1 \
  && ./obj_dir/isf_sim > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
